/* common/slide_defines.svh */
// Default image size, debounce timing, settle delay and touch gesture codes
`ifndef SLIDE_DEFINES_SVH
`define SLIDE_DEFINES_SVH

// ====================
// Image geometry
// ====================

// 800 x 480 pixels, one 32-bit word each
`define SLIDE_PIX_PER_IMG 384000

// ====================
// Gesture debounce
// ====================

// Delay from gesture to slide pulse, 0.2 s at 33 MHz
`define SLIDE_PULSE_DLY 6600000

// Rearm time after a gesture, 0.5 s at 33 MHz
`define SLIDE_HOLDOFF 16500000

// ====================
// Loading flag
// ====================

// Cycles between loading complete and loading low
`define SLIDE_LOAD_SETTLE 50

// Touch controller gesture codes
`define SLIDE_GESTURE_WEST 8'h1C
`define SLIDE_GESTURE_EAST 8'h14

`endif

/* common/slide_pkg.sv */
// Slideshow types for pixels, image indices, counts and frame addresses
package slide_pkg;

	// ====================
	// Widths
	// ====================

	localparam int PIXEL_W      = 24;
	localparam int IMG_IDX_W    = 5;
	localparam int IMG_CNT_W    = 8;
	localparam int PIX_CNT_W    = 32;
	localparam int FRAME_ADDR_W = 24;

	// ====================
	// Types
	// ====================

	// Red in [23:16], green in [15:8], blue in [7:0]
	typedef logic [PIXEL_W-1:0] pixel_t;

	// Index of the image on screen, up to 32 images
	typedef logic [IMG_IDX_W-1:0] img_idx_t;

	// Image count, first byte of the SPI stream
	typedef logic [IMG_CNT_W-1:0] img_cnt_t;

	// Stored pixel counter over all images
	typedef logic [PIX_CNT_W-1:0] pix_cnt_t;

	// Pixel word address on the read side
	typedef logic [FRAME_ADDR_W-1:0] frame_addr_t;

endpackage

/* common/wb_pkg.sv */
// Wishbone address, data and byte select types
package wb_pkg;

	localparam int WB_ADR_W = 24;
	localparam int WB_DAT_W = 32;
	localparam int WB_SEL_W = WB_DAT_W / 8;

	// Word address, one pixel per word
	typedef logic [WB_ADR_W-1:0] wb_adr_t;

	// Write data, zero byte above the pixel
	typedef logic [WB_DAT_W-1:0] wb_dat_t;

	// One select bit per byte lane
	typedef logic [WB_SEL_W-1:0] wb_sel_t;

endpackage

/* flist.f */
+incdir+common
common/slide_pkg.sv
common/wb_pkg.sv
spi_rx/spi_pixel_decoder.sv
sequencer/gesture_debounce.sv
sequencer/slide_sequencer.sv
src/frame_addr_gen.sv
src/pixel_wb_writer.sv
src/slideshow_top.sv
verification/slideshow_tb.sv

/* sequencer/gesture_debounce.sv */
// Delayed single pulse with holdoff for one touch gesture code
`timescale 1ns/1ps
`include "slide_defines.svh"

module gesture_debounce #(
	parameter logic [7:0] GESTURE_CODE = `SLIDE_GESTURE_WEST,
	parameter int         PULSE_DLY    = `SLIDE_PULSE_DLY,
	parameter int         HOLDOFF      = `SLIDE_HOLDOFF
) (
	input  logic       CLOCK_33,
	input  logic       iRSTN,
	input  logic       touch_ready,
	input  logic [7:0] touch_gesture,
	output logic       pulse
);

	localparam int CNT_W = $clog2(HOLDOFF + 1);

	logic             trigger;
	logic             active;
	logic [CNT_W-1:0] cnt;

	// Ready strobe with our own gesture code
	assign trigger = touch_ready && (touch_gesture == GESTURE_CODE);

	// Count holds k in the k-th cycle after the trigger
	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			active <= 1'b0;
			cnt    <= '0;
		end else if (!active) begin
			if (trigger) begin
				active <= 1'b1;
				cnt    <= CNT_W'(1);
			end
		end else if (cnt == CNT_W'(HOLDOFF)) begin
			// Rearm, one swipe never skips two slides
			active <= 1'b0;
			cnt    <= '0;
		end else begin
			cnt <= cnt + CNT_W'(1);
		end
	end

	assign pulse = active && (cnt == CNT_W'(PULSE_DLY));

endmodule

/* sequencer/slide_sequencer.sv */
// Stored pixel counter, loading flag and current image selection from swipes
`timescale 1ns/1ps
`include "slide_defines.svh"

module slide_sequencer import slide_pkg::*; #(
	parameter int PIX_PER_IMG = `SLIDE_PIX_PER_IMG,
	parameter int PULSE_DLY   = `SLIDE_PULSE_DLY,
	parameter int HOLDOFF     = `SLIDE_HOLDOFF
) (
	input  logic       CLOCK_33,
	input  logic       iRSTN,
	input  img_cnt_t   img_num,
	input  logic       pix_stored,
	input  logic       touch_ready,
	input  logic [7:0] touch_gesture,
	output logic       loading,
	output img_idx_t   current_img
);

	localparam int SETTLE_W = $clog2(`SLIDE_LOAD_SETTLE + 1);

	pix_cnt_t            pix_cnt;
	pix_cnt_t            pix_total;
	logic                loaded;
	logic [SETTLE_W-1:0] settle_cnt;
	logic                settle_done;
	img_idx_t            img_last;
	logic                pulse_w, pulse_e;

	// One debouncer per swipe direction
	gesture_debounce #(
		.GESTURE_CODE (`SLIDE_GESTURE_WEST),
		.PULSE_DLY    (PULSE_DLY),
		.HOLDOFF      (HOLDOFF)
	) west_i (
		.CLOCK_33      (CLOCK_33),
		.iRSTN         (iRSTN),
		.touch_ready   (touch_ready),
		.touch_gesture (touch_gesture),
		.pulse         (pulse_w)
	);

	gesture_debounce #(
		.GESTURE_CODE (`SLIDE_GESTURE_EAST),
		.PULSE_DLY    (PULSE_DLY),
		.HOLDOFF      (HOLDOFF)
	) east_i (
		.CLOCK_33      (CLOCK_33),
		.iRSTN         (iRSTN),
		.touch_ready   (touch_ready),
		.touch_gesture (touch_gesture),
		.pulse         (pulse_e)
	);

	// ====================
	// Load progress
	// ====================

	assign pix_total   = pix_cnt_t'(img_num) * pix_cnt_t'(PIX_PER_IMG);
	assign loaded      = (img_num != '0) && (pix_cnt == pix_total);
	assign settle_done = (settle_cnt == SETTLE_W'(`SLIDE_LOAD_SETTLE));
	assign img_last    = img_idx_t'(img_num) - img_idx_t'(1);

	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			pix_cnt    <= '0;
			settle_cnt <= '0;
			loading    <= 1'b0;
		end else begin
			if (pix_stored)
				pix_cnt <= pix_cnt + pix_cnt_t'(1);
			// Settle delay before handing the screen to the display
			if (loaded && !settle_done)
				settle_cnt <= settle_cnt + SETTLE_W'(1);
			if (loaded && settle_done)
				loading <= 1'b0;
			else if (pix_stored)
				loading <= 1'b1;
		end
	end

	// ====================
	// Image selection
	// ====================

	// East steps back, west steps forward, both wrap
	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			current_img <= '0;
		end else if (loaded) begin
			if (pulse_e)
				current_img <= (current_img == '0) ? img_last : current_img - img_idx_t'(1);
			else if (pulse_w)
				current_img <= (current_img == img_last) ? '0 : current_img + img_idx_t'(1);
		end
	end

endmodule

/* spi_rx/spi_pixel_decoder.sv */
// SPI slave byte receiver with image count and RGB pixel assembly
`timescale 1ns/1ps

module spi_pixel_decoder import slide_pkg::*; (
	input  logic     CLOCK_33,
	input  logic     iRSTN,
	input  logic     spi_sclk,
	input  logic     spi_cs_n,
	input  logic     spi_mosi,
	output img_cnt_t img_num,
	output pixel_t   pixel,
	output logic     pixel_valid
);

	// Byte phase within a transfer
	localparam logic [1:0] PH_COUNT = 2'd0;
	localparam logic [1:0] PH_RED   = 2'd1;
	localparam logic [1:0] PH_GREEN = 2'd2;
	localparam logic [1:0] PH_BLUE  = 2'd3;

	logic       sclk_s1, sclk_s2, sclk_s3;
	logic       cs_s1, cs_s2;
	logic       mosi_s1, mosi_s2;
	logic       sclk_rise;
	logic [6:0] shift;
	logic [2:0] bit_cnt;
	logic [1:0] phase;
	logic       byte_done;
	logic [7:0] rx_byte;

	// ====================
	// Pin synchronizers
	// ====================

	// MOSI goes through the same depth so it lines up with the sclk edge
	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			sclk_s1 <= 1'b0;
			sclk_s2 <= 1'b0;
			sclk_s3 <= 1'b0;
			cs_s1   <= 1'b1;
			cs_s2   <= 1'b1;
			mosi_s1 <= 1'b0;
			mosi_s2 <= 1'b0;
		end else begin
			sclk_s1 <= spi_sclk;
			sclk_s2 <= sclk_s1;
			sclk_s3 <= sclk_s2;
			cs_s1   <= spi_cs_n;
			cs_s2   <= cs_s1;
			mosi_s1 <= spi_mosi;
			mosi_s2 <= mosi_s1;
		end
	end

	// Mode 0, sample on rising sclk
	assign sclk_rise = sclk_s2 && !sclk_s3;

	// Eighth bit closes the byte
	assign byte_done = sclk_rise && !cs_s2 && (bit_cnt == 3'd7);
	assign rx_byte   = {shift, mosi_s2};

	// ====================
	// Bit and byte phase
	// ====================

	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			bit_cnt     <= '0;
			phase       <= PH_COUNT;
			img_num     <= '0;
			pixel_valid <= 1'b0;
		end else begin
			pixel_valid <= byte_done && (phase == PH_BLUE);
			if (cs_s2) begin
				// Deselected, next transfer starts with the count
				bit_cnt <= '0;
				phase   <= PH_COUNT;
			end else if (sclk_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (byte_done) begin
					if (phase == PH_COUNT)
						img_num <= rx_byte;
					// After blue go back to red, never to the count
					phase <= (phase == PH_BLUE) ? PH_RED : phase + 2'd1;
				end
			end
		end
	end

	// ====================
	// Data shift and pixel fields
	// ====================

	always_ff @(posedge CLOCK_33) begin
		if (sclk_rise && !cs_s2)
			shift <= rx_byte[6:0];
		if (byte_done) begin
			case (phase)
				PH_RED:   pixel[23:16] <= rx_byte;
				PH_GREEN: pixel[15:8]  <= rx_byte;
				PH_BLUE:  pixel[7:0]   <= rx_byte;
				default:  ;
			endcase
		end
	end

endmodule

/* src/frame_addr_gen.sv */
// Read window and read reload strobe for the display side
`timescale 1ns/1ps
`include "slide_defines.svh"

module frame_addr_gen import slide_pkg::*; #(
	parameter int PIX_PER_IMG = `SLIDE_PIX_PER_IMG
) (
	input  logic        CLOCK_33,
	input  logic        iRSTN,
	input  img_idx_t    current_img,
	input  logic        end_frame,
	input  logic        new_frame,
	output frame_addr_t base_addr,
	output frame_addr_t limit_addr,
	output logic        read_load
);

	frame_addr_t next_base;

	// First word of the selected image
	assign next_base = frame_addr_t'(current_img) * frame_addr_t'(PIX_PER_IMG);

	// Window only moves between frames
	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			base_addr  <= '0;
			limit_addr <= frame_addr_t'(PIX_PER_IMG);
			read_load  <= 1'b0;
		end else begin
			if (end_frame) begin
				base_addr  <= next_base;
				limit_addr <= next_base + frame_addr_t'(PIX_PER_IMG);
			end
			read_load <= new_frame;
		end
	end

endmodule

/* src/pixel_wb_writer.sv */
// Wishbone classic write master with one pixel holding register
`timescale 1ns/1ps

module pixel_wb_writer import slide_pkg::*, wb_pkg::*; (
	input  logic    CLOCK_33,
	input  logic    iRSTN,
	input  pixel_t  pixel,
	input  logic    pixel_valid,
	input  logic    wb_ack,
	output logic    wb_cyc,
	output logic    wb_stb,
	output logic    wb_we,
	output wb_adr_t wb_adr,
	output wb_dat_t wb_wdat,
	output wb_sel_t wb_sel,
	output logic    pix_stored,
	output logic    overflow
);

	wb_adr_t wr_idx;
	pixel_t  hold_pix;
	logic    hold_full;
	logic    start_hold;
	logic    start_new;
	logic    to_hold;
	logic    drop;

	// ====================
	// Issue decisions
	// ====================

	// Held pixel has priority over a fresh one
	assign start_hold = !wb_cyc && hold_full;
	assign start_new  = !wb_cyc && !hold_full && pixel_valid;
	assign to_hold    = pixel_valid && (wb_cyc ? !hold_full : hold_full);
	assign drop       = pixel_valid && wb_cyc && hold_full;

	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			wb_cyc    <= 1'b0;
			hold_full <= 1'b0;
			overflow  <= 1'b0;
			wr_idx    <= '0;
		end else begin
			if (wb_cyc && wb_ack) begin
				// Drop the cycle right after the ack
				wb_cyc <= 1'b0;
				wr_idx <= wr_idx + wb_adr_t'(1);
			end else if (start_hold || start_new) begin
				wb_cyc <= 1'b1;
			end
			if (to_hold)
				hold_full <= 1'b1;
			else if (start_hold)
				hold_full <= 1'b0;
			// Sticky until reset
			if (drop)
				overflow <= 1'b1;
		end
	end

	// Payload, stable for the whole bus cycle
	always_ff @(posedge CLOCK_33) begin
		if (start_hold)
			wb_wdat <= {8'h00, hold_pix};
		else if (start_new)
			wb_wdat <= {8'h00, pixel};
		if (to_hold)
			hold_pix <= pixel;
	end

	// ====================
	// Bus outputs
	// ====================

	assign wb_stb     = wb_cyc;
	assign wb_we      = wb_cyc;
	assign wb_sel     = '1;
	assign wb_adr     = wr_idx;
	assign pix_stored = wb_cyc && wb_ack;

endmodule

/* src/slideshow_top.sv */
// Slideshow top level with SPI decoder, Wishbone writer, sequencer and address generator
`timescale 1ns/1ps
`include "slide_defines.svh"

module slideshow_top import slide_pkg::*, wb_pkg::*; #(
	parameter int PIX_PER_IMG = `SLIDE_PIX_PER_IMG,
	parameter int PULSE_DLY   = `SLIDE_PULSE_DLY,
	parameter int HOLDOFF     = `SLIDE_HOLDOFF
) (
	input  logic        CLOCK_33,
	input  logic        iRSTN,
	// SPI from the host board
	input  logic        spi_sclk,
	input  logic        spi_cs_n,
	input  logic        spi_mosi,
	// Touch controller results
	input  logic        touch_ready,
	input  logic [7:0]  touch_gesture,
	// Display timing strobes
	input  logic        end_frame,
	input  logic        new_frame,
	// Wishbone master to frame memory
	input  logic        wb_ack,
	output logic        wb_cyc,
	output logic        wb_stb,
	output logic        wb_we,
	output wb_adr_t     wb_adr,
	output wb_dat_t     wb_wdat,
	output wb_sel_t     wb_sel,
	// Read window for the display side
	output frame_addr_t base_addr,
	output frame_addr_t limit_addr,
	output logic        read_load,
	// Status
	output logic        loading,
	output img_idx_t    current_img,
	output logic        overflow
);

	img_cnt_t img_num;
	pixel_t   pixel;
	logic     pixel_valid;
	logic     pix_stored;

	// ====================
	// Load path
	// ====================

	spi_pixel_decoder decoder_i (
		.CLOCK_33    (CLOCK_33),
		.iRSTN       (iRSTN),
		.spi_sclk    (spi_sclk),
		.spi_cs_n    (spi_cs_n),
		.spi_mosi    (spi_mosi),
		.img_num     (img_num),
		.pixel       (pixel),
		.pixel_valid (pixel_valid)
	);

	pixel_wb_writer writer_i (
		.CLOCK_33    (CLOCK_33),
		.iRSTN       (iRSTN),
		.pixel       (pixel),
		.pixel_valid (pixel_valid),
		.wb_ack      (wb_ack),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_wdat     (wb_wdat),
		.wb_sel      (wb_sel),
		.pix_stored  (pix_stored),
		.overflow    (overflow)
	);

	// ====================
	// Selection and display
	// ====================

	slide_sequencer #(
		.PIX_PER_IMG (PIX_PER_IMG),
		.PULSE_DLY   (PULSE_DLY),
		.HOLDOFF     (HOLDOFF)
	) sequencer_i (
		.CLOCK_33      (CLOCK_33),
		.iRSTN         (iRSTN),
		.img_num       (img_num),
		.pix_stored    (pix_stored),
		.touch_ready   (touch_ready),
		.touch_gesture (touch_gesture),
		.loading       (loading),
		.current_img   (current_img)
	);

	frame_addr_gen #(
		.PIX_PER_IMG (PIX_PER_IMG)
	) addr_gen_i (
		.CLOCK_33    (CLOCK_33),
		.iRSTN       (iRSTN),
		.current_img (current_img),
		.end_frame   (end_frame),
		.new_frame   (new_frame),
		.base_addr   (base_addr),
		.limit_addr  (limit_addr),
		.read_load   (read_load)
	);

endmodule

/* verification/slideshow_tb.sv */
// Slideshow testbench with clock, SPI host, Wishbone slave model, reference and checker
`timescale 1ns/1ps
`include "slide_defines.svh"

module slideshow_tb import slide_pkg::*, wb_pkg::*; ();

	localparam int PIX       = 4;
	localparam int PULSE_DLY = 20;
	localparam int HOLDOFF   = 60;
	localparam int N_IMG     = 3;
	localparam int N_PIX     = N_IMG * PIX;
	localparam int HALF      = 4;
	localparam int SETTLE    = `SLIDE_LOAD_SETTLE;
	// Watchdog budget as twice the SPI bit time plus gesture waits
	localparam int SPI_CYCLES  = (1 + 3 * N_PIX) * 8 * 2 * HALF;
	localparam int GEST_CYCLES = 8 * (HOLDOFF + 20) + SETTLE;
	localparam int TIMEOUT_NS  = 2 * (SPI_CYCLES + GEST_CYCLES) * 10;

	logic        CLOCK_33;
	logic        iRSTN;
	logic        spi_sclk, spi_cs_n, spi_mosi;
	logic        touch_ready;
	logic [7:0]  touch_gesture;
	logic        end_frame, new_frame;
	logic        wb_ack;
	logic        wb_cyc, wb_stb, wb_we;
	wb_adr_t     wb_adr;
	wb_dat_t     wb_wdat;
	wb_sel_t     wb_sel;
	frame_addr_t base_addr, limit_addr;
	logic        read_load, loading, overflow;
	img_idx_t    current_img;

	// Stimulus colors and bookkeeping
	logic [7:0]  red_v[N_PIX];
	logic [7:0]  green_v[N_PIX];
	logic [7:0]  blue_v[N_PIX];
	logic [31:0] rng_state;
	logic [55:0] wr_q[$];
	int          write_count = 0;
	int          errors = 0;

	slideshow_top #(
		.PIX_PER_IMG (PIX),
		.PULSE_DLY   (PULSE_DLY),
		.HOLDOFF     (HOLDOFF)
	) dut_i (
		.CLOCK_33      (CLOCK_33),
		.iRSTN         (iRSTN),
		.spi_sclk      (spi_sclk),
		.spi_cs_n      (spi_cs_n),
		.spi_mosi      (spi_mosi),
		.touch_ready   (touch_ready),
		.touch_gesture (touch_gesture),
		.end_frame     (end_frame),
		.new_frame     (new_frame),
		.wb_ack        (wb_ack),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_we         (wb_we),
		.wb_adr        (wb_adr),
		.wb_wdat       (wb_wdat),
		.wb_sel        (wb_sel),
		.base_addr     (base_addr),
		.limit_addr    (limit_addr),
		.read_load     (read_load),
		.loading       (loading),
		.current_img   (current_img),
		.overflow      (overflow)
	);

	// 10 ns clock
	initial CLOCK_33 = 1'b0;
	always #5 CLOCK_33 = ~CLOCK_33;

	// ====================
	// Helpers
	// ====================

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// Address in the upper bits with zero byte and red, green, blue below
	function automatic logic [55:0] expected_write(input int n);
		return {wb_adr_t'(n), 8'h00, red_v[n], green_v[n], blue_v[n]};
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		errors++;
		$display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
	endtask

	// Returns 1 ns past a rising edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge CLOCK_33);
		#1;
	endtask

	// Mode 0 with MSB first
	task automatic spi_send_byte(input logic [7:0] b);
		for (int i = 7; i >= 0; i--) begin
			spi_mosi = b[i];
			wait_cycles(HALF);
			spi_sclk = 1'b1;
			wait_cycles(HALF);
			spi_sclk = 1'b0;
		end
	endtask

	task automatic send_gesture(input logic [7:0] code);
		touch_gesture = code;
		touch_ready   = 1'b1;
		wait_cycles(1);
		touch_ready   = 1'b0;
		touch_gesture = 8'h00;
	endtask

	// End of frame then new frame for the expected image window
	task automatic check_frame(input int exp_img);
		end_frame = 1'b1;
		wait_cycles(1);
		end_frame = 1'b0;
		if (base_addr !== frame_addr_t'(exp_img * PIX))
			report_mismatch("base_addr", base_addr, exp_img * PIX);
		if (limit_addr !== frame_addr_t'(exp_img * PIX + PIX))
			report_mismatch("limit_addr", limit_addr, exp_img * PIX + PIX);
		new_frame = 1'b1;
		wait_cycles(1);
		new_frame = 1'b0;
		if (read_load !== 1'b1)
			report_mismatch("read_load after new_frame", read_load, 1);
		wait_cycles(1);
		if (read_load !== 1'b0)
			report_mismatch("read_load one cycle later", read_load, 0);
	endtask

	task automatic gesture_step(input logic [7:0] code, input int exp_img);
		send_gesture(code);
		wait_cycles(HOLDOFF + 10);
		if (current_img !== img_idx_t'(exp_img))
			report_mismatch("current_img", current_img, exp_img);
		check_frame(exp_img);
	endtask

	// ====================
	// Wishbone slave model
	// ====================

	// Captures each write at its start and acks after 0 to 3 cycles
	initial begin : wb_slave
		int d;
		wb_ack = 1'b0;
		forever begin
			@(posedge CLOCK_33);
			#1;
			if (wb_cyc && wb_stb) begin
				wr_q.push_back({wb_adr, wb_wdat});
				d = next_rand() % 4;
				if (d > 0)
					wait_cycles(d);
				wb_ack = 1'b1;
				wait_cycles(1);
				wb_ack = 1'b0;
			end
		end
	end

	// Checks every ack against the reference in mid cycle
	always @(negedge CLOCK_33) begin : compare
		logic [55:0] exp;
		logic [55:0] got;
		if (wb_cyc && wb_ack) begin
			if (write_count >= N_PIX) begin
				errors++;
				$display("An extra pixel write appeared after all %0d pixels", N_PIX);
			end else begin
				exp = expected_write(write_count);
				got = wr_q.pop_front();
				if (got[31:0] !== exp[31:0])
					report_mismatch("write data at start", got[31:0], exp[31:0]);
				if (got[55:32] !== exp[55:32])
					report_mismatch("write address at start", got[55:32], exp[55:32]);
				if ({wb_adr, wb_wdat} !== exp)
					report_mismatch("write data at ack", wb_wdat, exp[31:0]);
				if (!wb_stb || !wb_we || wb_sel !== 4'hF)
					report_mismatch("stb, we, sel", {wb_stb, wb_we, wb_sel}, 6'h3F);
				if (overflow !== 1'b0)
					report_mismatch("overflow", overflow, 0);
				// Loading rises after the first store and stays up to the last
				if (write_count >= 1 && loading !== 1'b1)
					report_mismatch("loading during load", loading, 1);
			end
			write_count++;
		end
	end

	// ====================
	// Main sequence
	// ====================

	initial begin : stimulus
		logic [31:0] r;
		int          k;
		iRSTN         = 1'b0;
		spi_sclk      = 1'b0;
		spi_cs_n      = 1'b1;
		spi_mosi      = 1'b0;
		touch_ready   = 1'b0;
		touch_gesture = 8'h00;
		end_frame     = 1'b0;
		new_frame     = 1'b0;
		rng_state     = 32'd18;
		for (int i = 0; i < N_PIX; i++) begin
			r = next_rand();
			red_v[i]   = r[7:0];
			green_v[i] = r[15:8];
			blue_v[i]  = r[23:16];
		end
		wait_cycles(2);
		iRSTN = 1'b1;
		wait_cycles(1);

		// Idle state after reset
		if (wb_cyc !== 1'b0 || wb_stb !== 1'b0)
			report_mismatch("wb_cyc, wb_stb after reset", {wb_cyc, wb_stb}, 0);
		if (read_load !== 1'b0 || loading !== 1'b0 || overflow !== 1'b0)
			report_mismatch("read_load, loading, overflow", {read_load, loading, overflow}, 0);
		if (current_img !== '0)
			report_mismatch("current_img after reset", current_img, 0);
		if (base_addr !== '0)
			report_mismatch("base_addr after reset", base_addr, 0);
		if (limit_addr !== frame_addr_t'(PIX))
			report_mismatch("limit_addr after reset", limit_addr, PIX);

		// Count byte and first pixel
		spi_cs_n = 1'b0;
		wait_cycles(HALF);
		spi_send_byte(8'(N_IMG));
		spi_send_byte(red_v[0]);
		spi_send_byte(green_v[0]);
		spi_send_byte(blue_v[0]);

		// Swipe while still loading has no effect
		send_gesture(`SLIDE_GESTURE_WEST);
		wait_cycles(PULSE_DLY + 10);
		if (current_img !== '0)
			report_mismatch("current_img while loading", current_img, 0);

		for (int i = 1; i < N_PIX; i++) begin
			spi_send_byte(red_v[i]);
			spi_send_byte(green_v[i]);
			spi_send_byte(blue_v[i]);
		end
		wait_cycles(HALF);
		spi_cs_n = 1'b1;

		k = 0;
		while (write_count < N_PIX && k < 200) begin
			wait_cycles(1);
			k++;
		end
		if (write_count < N_PIX) begin
			errors++;
			$display("Only %0d of %0d pixel writes arrived in time", write_count, N_PIX);
		end

		// Loading drops after the settle delay
		k = 0;
		while (loading && k < SETTLE + 20) begin
			wait_cycles(1);
			k++;
		end
		if (loading !== 1'b0)
			report_mismatch("loading after settle", loading, 0);

		// Wrap forward and back with gaps beyond the holdoff
		gesture_step(`SLIDE_GESTURE_WEST, 1);
		gesture_step(`SLIDE_GESTURE_WEST, 2);
		gesture_step(`SLIDE_GESTURE_WEST, 0);
		gesture_step(`SLIDE_GESTURE_EAST, 2);

		// Second swipe after the pulse but inside the holdoff is ignored
		send_gesture(`SLIDE_GESTURE_WEST);
		wait_cycles(PULSE_DLY + 10);
		gesture_step(`SLIDE_GESTURE_WEST, 0);

		if (write_count != N_PIX)
			report_mismatch("pixel write count", write_count, N_PIX);
		if (wr_q.size() != 0) begin
			errors++;
			$display("%0d bus cycles were started and never acknowledged", wr_q.size());
		end
		if (overflow !== 1'b0 || loading !== 1'b0)
			report_mismatch("overflow, loading at end", {overflow, loading}, 0);

		$display("Pixel writes: %0d of %0d, errors: %0d", write_count, N_PIX, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// Hang guard
	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("Watchdog timeout after %0d ns, the test did not finish", TIMEOUT_NS);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule
